// File: Makefile
SRCS := $(shell cat flist.f)

.PHONY: run clean

run: obj_dir/Vquad_bram_ctrl_tb
	./obj_dir/Vquad_bram_ctrl_tb > sim.log 2>&1 || true
	cat sim.log
	! grep -q "sim failed" sim.log
	grep -q "sim passed" sim.log

obj_dir/Vquad_bram_ctrl_tb: flist.f $(SRCS) bench/quad_testdata.txt
	verilator --binary --timing --assert --top-module quad_bram_ctrl_tb -f flist.f

clean:
	rm -rf obj_dir sim.log

// File: bench/quad_bram_ctrl_properties.sv
module quad_bram_ctrl_properties
    import quad_cfg_pkg::*;
    import quad_types_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input fetch_resp_t fetch_resp,
    input logic        job_accept,
    input logic        job_fetch_request,
    input logic        pfb_rden,
    input logic        seq_rden
);

    // Length of the accept burst so far
    int accept_run;

    always_ff @(posedge clk) begin
        if (rst || !job_accept) begin
            accept_run <= 0;
        end else begin
            accept_run <= accept_run + 1;
        end
    end

    //////////////////////////////
    // Job and fetch handshake
    //////////////////////////////

    accept_length: assert property (
        @(posedge clk) disable iff (rst) $fell(job_accept) |-> accept_run == ACCEPT_CYCLES
    ) else $error("job_accept burst ended at the wrong length");

    accept_max: assert property (
        @(posedge clk) disable iff (rst) accept_run <= ACCEPT_CYCLES
    ) else $error("job_accept burst longer than ACCEPT_CYCLES");

    // Request drops right after its ack
    fetch_drop: assert property (
        @(posedge clk) disable iff (rst) (job_fetch_request && fetch_resp.ack) |=> !job_fetch_request
    ) else $error("job_fetch_request still high the cycle after ack");

    // PFB reads and sequencer reads share the BRAM port
    rden_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(pfb_rden && seq_rden)
    ) else $error("pfb_rden and seq_rden high together");

endmodule

bind quad_bram_ctrl quad_bram_ctrl_properties props (
    .clk               (clk),
    .rst               (rst),
    .fetch_resp        (fetch_resp),
    .job_accept        (job_accept),
    .job_fetch_request (job_fetch_request),
    .pfb_rden          (pfb_rden),
    .seq_rden          (seq_rden)
);

// File: bench/quad_bram_ctrl_tb.sv
module quad_bram_ctrl_tb
    import quad_cfg_pkg::*;
    import quad_types_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 5;
    localparam int JOB_TIMEOUT = 5000;

    // One line of the data file
    typedef struct packed {
        int num_cols;
        int num_rows;
        int full_count;
        int ack_delay;
        int complete_delay;
        int complete_ack_delay;
    } test_job_t;

    logic        clk;
    logic        rst;
    job_cfg_t    job_cfg;
    logic        job_start;
    fetch_resp_t fetch_resp;
    logic        next_row;
    logic        job_complete_ack;
    logic        job_accept;
    logic        job_fetch_request;
    logic        pfb_rden;
    logic        seq_rden;
    seq_out_t    seq_out;
    logic        job_complete;

    test_job_t   jobs[$];
    logic [31:0] lfsr;
    // Model of the PFB fill level across jobs
    int          pfb_words;
    // next_row pulses since reset for the Gray code
    int          total_pulses;
    int          errors;
    int          failed_tests;
    int          tests_run;
    logic        timed_out;

    quad_bram_ctrl uut (
        .clk               (clk),
        .rst               (rst),
        .job_cfg           (job_cfg),
        .job_start         (job_start),
        .fetch_resp        (fetch_resp),
        .next_row          (next_row),
        .job_complete_ack  (job_complete_ack),
        .job_accept        (job_accept),
        .job_fetch_request (job_fetch_request),
        .pfb_rden          (pfb_rden),
        .seq_rden          (seq_rden),
        .seq_out           (seq_out),
        .job_complete      (job_complete)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Galois LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // Idle cycles between next_row pulses from 0 to 3
    task automatic draw_gap(output int gap);
        gap = 0;
        repeat (2) begin
            gap = (gap << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // Row code sequence 00 01 11 10
    function automatic int gray_of(input int count);
        case (count % 4)
            0: return 0;
            1: return 1;
            2: return 3;
            default: return 2;
        endcase
    endfunction

    task automatic check_value(input string test, input string what, input int exp,
                               input int act);
        assert (exp == act) else begin
            $display("ERR %s %s: expected %0d, actual %0d", test, what, exp, act);
            errors++;
        end
    endtask

    task automatic expect_true(input string test, input logic ok, input string problem);
        assert (ok) else begin
            $display("%s: %s", test, problem);
            errors++;
        end
    endtask

    task automatic load_jobs();
        int        fd;
        int        n;
        string     line;
        test_job_t job;

        fd = $fopen("bench/quad_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/quad_testdata.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                // Comment lines start with #
                if (n > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%d %d %d %d %d %d", job.num_cols, job.num_rows,
                                job.full_count, job.ack_delay, job.complete_delay,
                                job.complete_ack_delay);
                    if (n == 6) begin
                        jobs.push_back(job);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    //////////////////////////////
    // One job, cycle by cycle
    //////////////////////////////

    task automatic run_job(input int idx, input test_job_t job);
        string                 name;
        int                    n_out;
        int                    n_prime;
        int                    exp_fetches;
        int                    carry;
        int                    taken;
        int                    errors_at_start;
        int                    cyc;
        int                    i;
        int                    acc_cycles;
        int                    rd_count;
        int                    req_count;
        int                    first_event;
        int                    fstate;
        int                    ftimer;
        int                    rise_cyc;
        int                    sent;
        int                    gap;
        int                    last_pulse;
        int                    done_cyc;
        int                    ack_timer;
        logic                  req_q;
        logic                  acked;
        logic                  finished;
        logic                  start_lvl;
        logic                  drv_ack;
        logic                  drv_complete;
        logic                  drv_next_row;
        logic                  drv_cack;
        logic [CE_START_W-1:0] exp_ce;

        name = $sformatf("job%0d", idx);
        errors_at_start = errors;
        n_out = (job.num_rows + 1) * (job.num_cols + 1);
        // A map shorter than PRIME_ROWS is primed whole
        n_prime = (job.num_rows + 1 < PRIME_ROWS ? job.num_rows + 1 : PRIME_ROWS)
                  * (job.num_cols + 1);

        // Fetches needed beyond the words left by the last job
        exp_fetches = 0;
        carry = pfb_words;
        taken = 0;
        while (taken < n_prime && (carry > 0 || job.full_count > 0)) begin
            if (carry == 0) begin
                exp_fetches++;
                carry = job.full_count;
            end
            carry--;
            taken++;
        end

        // Which came first on an empty PFB
        // 0 neither yet
        // 1 fetch request
        // 2 PFB read
        // 3 PFB was not empty at job start
        first_event = (pfb_words == 0) ? 0 : 3;
        cyc = 0;
        acc_cycles = 0;
        rd_count = 0;
        req_count = 0;
        fstate = 0;
        ftimer = 0;
        rise_cyc = -1;
        sent = 0;
        last_pulse = -1;
        done_cyc = -1;
        ack_timer = 0;
        req_q = 1'b0;
        acked = 1'b0;
        finished = 1'b0;
        start_lvl = 1'b1;
        draw_gap(gap);

        @(posedge clk);
        #2;
        job_cfg.num_cols = COORD_W'(job.num_cols);
        job_cfg.num_rows = COORD_W'(job.num_rows);
        job_start = 1'b1;

        while (!finished && cyc < JOB_TIMEOUT) begin
            @(posedge clk);
            #1;
            drv_ack = 1'b0;
            drv_complete = 1'b0;
            drv_next_row = 1'b0;
            drv_cack = 1'b0;

            // Start level drops once the accept burst is seen
            if (cyc == 0) begin
                check_value(name, "job_accept after job_start", 1, int'(job_accept));
            end
            if (job_accept && done_cyc < 0) begin
                acc_cycles++;
                start_lvl = 1'b0;
            end

            // Fetch requests and PFB reads
            if (job_fetch_request && !req_q) begin
                req_count++;
                if (first_event == 0) begin
                    first_event = 1;
                end
            end
            req_q = job_fetch_request;
            if (pfb_rden) begin
                rd_count++;
                if (first_event == 0) begin
                    first_event = 2;
                end
                expect_true(name, pfb_words > 0, "pfb_rden while the PFB holds no words");
                if (pfb_words > 0) begin
                    pfb_words--;
                end
            end

            // Environment side of the fetch
            if (fstate == 0 && job_fetch_request) begin
                fstate = 1;
                ftimer = job.ack_delay;
            end
            if (fstate == 1) begin
                expect_true(name, job_fetch_request, "fetch request dropped before its ack");
                if (ftimer == 0) begin
                    drv_ack = 1'b1;
                    fstate = 2;
                    ftimer = job.complete_delay;
                end else begin
                    ftimer--;
                end
            end else if (fstate == 2) begin
                if (ftimer == 0) begin
                    drv_complete = 1'b1;
                    pfb_words = job.full_count;
                    fstate = 0;
                end else begin
                    ftimer--;
                end
            end

            // First seq_rden ends priming
            if (seq_rden && rise_cyc < 0) begin
                rise_cyc = cyc;
                check_value(name, "pfb_rden count", n_prime, rd_count);
            end

            // CE start chain and cycle counter relative to the seq_rden rise
            if (rise_cyc >= 0) begin
                i = cyc - rise_cyc;
                if (i < CE_START_W + 3) begin
                    exp_ce = '0;
                    for (int k = 0; k < CE_START_W; k++) begin
                        exp_ce[k] = (i >= 3 + k);
                    end
                    check_value(name, "ce_start", int'(exp_ce), int'(seq_out.ce_start));
                end
                if (i < 15) begin
                    check_value(name, "cycle_counter", (i < 4) ? 0 : (i - 4) % SEQ_CYCLES,
                                int'(seq_out.cycle_counter));
                end
                if (done_cyc < 0 && !job_complete) begin
                    expect_true(name, seq_rden, "seq_rden fell before the last next_row");
                end
            end

            check_value(name, "gray_code", gray_of(total_pulses), int'(seq_out.gray_code));

            // Output rows with gaps drawn from the LFSR
            if (rise_cyc >= 0 && sent < n_out && !job_complete) begin
                if (gap == 0) begin
                    drv_next_row = 1'b1;
                    sent++;
                    total_pulses++;
                    last_pulse = cyc;
                    draw_gap(gap);
                end else begin
                    gap--;
                end
            end

            // Completion seen
            if (job_complete && done_cyc < 0) begin
                done_cyc = cyc;
                check_value(name, "next_row pulses", n_out, sent);
                check_value(name, "cycles from last next_row", 1, cyc - last_pulse);
                check_value(name, "seq_rden with job_complete", 0, int'(seq_rden));
                check_value(name, "fetch requests", exp_fetches, req_count);
                ack_timer = job.complete_ack_delay;
                // Start held early must wait for the ack
                start_lvl = 1'b1;
            end

            // Done until acked
            if (done_cyc >= 0) begin
                if (acked) begin
                    check_value(name, "job_complete after ack", 0, int'(job_complete));
                    finished = 1'b1;
                end else begin
                    expect_true(name, job_complete, "job_complete dropped before its ack");
                    expect_true(name, !job_accept, "job accepted before job_complete_ack");
                    if (ack_timer == 0) begin
                        drv_cack = 1'b1;
                        start_lvl = 1'b0;
                        acked = 1'b1;
                    end else begin
                        ack_timer--;
                    end
                end
            end

            #1;
            job_start = start_lvl;
            fetch_resp.ack = drv_ack;
            fetch_resp.complete = drv_complete;
            fetch_resp.full_count = PFB_COUNT_W'(job.full_count);
            next_row = drv_next_row;
            job_complete_ack = drv_cack;
            cyc++;
        end

        if (!finished) begin
            $display("%s: timed out waiting for the job to complete", name);
            timed_out = 1'b1;
            failed_tests++;
        end else begin
            check_value(name, "job_accept cycles", ACCEPT_CYCLES, acc_cycles);
            if (first_event != 3) begin
                expect_true(name, first_event == 1,
                            "pfb_rden came before a fetch request on an empty PFB");
            end
            if (errors == errors_at_start) begin
                $display("%s ok: %0d reads, %0d fetches, %0d rows out", name, rd_count,
                         req_count, sent);
            end else begin
                $display("%s FAILED: %0d errors", name, errors - errors_at_start);
                failed_tests++;
            end
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        rst = 1'b1;
        job_cfg = '0;
        job_start = 1'b0;
        fetch_resp = '0;
        next_row = 1'b0;
        job_complete_ack = 1'b0;
        lfsr = 32'h784f_6ef0;
        pfb_words = 0;
        total_pulses = 0;
        errors = 0;
        failed_tests = 0;
        tests_run = 0;
        timed_out = 1'b0;

        load_jobs();
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;

        // A hung job leaves the DUT in an unknown state, so the rest are skipped
        foreach (jobs[j]) begin
            if (!timed_out) begin
                run_job(j, jobs[j]);
                tests_run++;
            end
        end

        $display("%0d tests run, %0d failed, %0d check errors", tests_run, failed_tests,
                 errors);
        if (!timed_out && errors == 0 && failed_tests == 0 && jobs.size() > 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: bench/quad_testdata.txt
# num_cols num_rows full_count ack_delay complete_delay complete_ack_delay
# decimal, num_cols and num_rows are the highest indices of the padded map
7 5 40 0 0 0
3 3 7 2 3 1
9 4 100 1 0 4
5 7 18 3 5 2
15 2 16 0 2 0
4 3 200 1 1 3

// File: design/quad_bram_ctrl.sv
module quad_bram_ctrl
    import quad_cfg_pkg::*;
    import quad_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  job_cfg_t    job_cfg,
    input  logic        job_start,
    input  fetch_resp_t fetch_resp,
    input  logic        next_row,
    input  logic        job_complete_ack,
    output logic        job_accept,
    output logic        job_fetch_request,
    output logic        pfb_rden,
    output logic        seq_rden,
    output seq_out_t    seq_out,
    output logic        job_complete
);

    logic [PFB_COUNT_W-1:0] pfb_count;
    logic [PFB_COUNT_W-1:0] pfb_count_d;
    logic                   pos_clear;
    map_pos_t               in_pos_q;
    logic                   in_map_end;
    logic                   out_map_end;

    //////////////////////////////
    // Control
    //////////////////////////////

    quad_job_fsm job_fsm (
        .clk               (clk),
        .rst               (rst),
        .job_start         (job_start),
        .job_complete_ack  (job_complete_ack),
        .fetch_resp        (fetch_resp),
        .pfb_count         (pfb_count),
        .pfb_count_d       (pfb_count_d),
        .in_row            (in_pos_q.row),
        .in_map_end        (in_map_end),
        .out_map_end       (out_map_end),
        .next_row          (next_row),
        .job_accept        (job_accept),
        .job_fetch_request (job_fetch_request),
        .pfb_rden          (pfb_rden),
        .seq_rden          (seq_rden),
        .pos_clear         (pos_clear),
        .job_complete      (job_complete)
    );

    quad_pfb_tracker pfb_tracker (
        .clk         (clk),
        .rst         (rst),
        .fetch_req   (job_fetch_request),
        .fetch_resp  (fetch_resp),
        .pfb_rden    (pfb_rden),
        .pfb_count   (pfb_count),
        .pfb_count_d (pfb_count_d)
    );

    //////////////////////////////
    // Positions and sequencing
    //////////////////////////////

    // Input side walks with PFB reads
    quad_map_position in_pos (
        .clk     (clk),
        .rst     (rst),
        .clear   (pos_clear),
        .advance (pfb_rden),
        .cfg     (job_cfg),
        .pos     (in_pos_q),
        .col_end (),
        .map_end (in_map_end)
    );

    // Output side walks with next_row
    quad_map_position out_pos (
        .clk     (clk),
        .rst     (rst),
        .clear   (pos_clear),
        .advance (next_row),
        .cfg     (job_cfg),
        .pos     (),
        .col_end (),
        .map_end (out_map_end)
    );

    quad_seq_timing seq_timing (
        .clk      (clk),
        .rst      (rst),
        .seq_rden (seq_rden),
        .next_row (next_row),
        .seq_out  (seq_out)
    );

endmodule

// File: design/quad_cfg_pkg.sv
package quad_cfg_pkg;

    //////////////////////////////
    // Row buffer geometry
    //////////////////////////////

    // Words per BRAM row buffer
    localparam int BRAM_DEPTH = 1024;

    // Map coordinates address half the buffer
    localparam int COORD_W = $clog2(BRAM_DEPTH) - 1;

    // PFB fill level as reported by the fetch reply
    localparam int PFB_COUNT_W = 9;

    //////////////////////////////
    // Convolution engines
    //////////////////////////////

    localparam int NUM_AWE = 4;
    localparam int NUM_CE_PER_AWE = 2;

    // One start bit per CE, staggered by a cycle each
    localparam int CE_START_W = NUM_AWE * NUM_CE_PER_AWE;

    //////////////////////////////
    // Timing
    //////////////////////////////

    // Input rows held before the sequencer may run
    localparam int PRIME_ROWS = 3;

    // Cycle counter wraps at this value
    localparam int SEQ_CYCLES = 5;

    // Accept pulse length in cycles
    localparam int ACCEPT_CYCLES = 5;

    // Depth of each of the two sequencer read delays
    localparam int SEQ_RDEN_DELAY = 2;

endpackage

// File: design/quad_delay_line.sv
module quad_delay_line #(
    parameter type T = logic,
    parameter int DEPTH = 1
) (
    input  logic clk,
    input  logic rst,
    input  T     din,
    output T     dout
);

    // One register per cycle of delay
    T stage [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= din;
            // Shift toward the output end
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign dout = stage[DEPTH-1];

endmodule

// File: design/quad_job_fsm.sv
module quad_job_fsm
    import quad_cfg_pkg::*;
    import quad_types_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   job_start,
    input  logic                   job_complete_ack,
    input  fetch_resp_t            fetch_resp,
    input  logic [PFB_COUNT_W-1:0] pfb_count,
    input  logic [PFB_COUNT_W-1:0] pfb_count_d,
    input  logic [COORD_W-1:0]     in_row,
    input  logic                   in_map_end,
    input  logic                   out_map_end,
    input  logic                   next_row,
    output logic                   job_accept,
    output logic                   job_fetch_request,
    output logic                   pfb_rden,
    output logic                   seq_rden,
    output logic                   pos_clear,
    output logic                   job_complete
);

    job_state_t               state;
    logic [ACCEPT_CYCLES-1:0] accept_sr;
    logic                     fetch_acked;
    logic                     in_map_read;
    logic                     primed;
    logic                     fetch_done;

    //////////////////////////////
    // Job start
    //////////////////////////////

    // Start seen in idle, positions clear on the same edge
    assign pos_clear = (state == st_idle) && job_start;

    // Accept stays high while the start bit walks through
    always_ff @(posedge clk) begin
        if (rst) begin
            accept_sr <= '0;
        end else begin
            accept_sr <= {accept_sr[ACCEPT_CYCLES-2:0], pos_clear};
        end
    end

    assign job_accept = |accept_sr;

    //////////////////////////////
    // Priming status
    //////////////////////////////

    // Small maps end before PRIME_ROWS is reached
    always_ff @(posedge clk) begin
        if (rst || pos_clear) begin
            in_map_read <= 1'b0;
        end else if (pfb_rden && in_map_end) begin
            in_map_read <= 1'b1;
        end
    end

    assign primed = (in_row == COORD_W'(PRIME_ROWS)) || in_map_read;

    // Fetch counts as done only after its ack
    assign fetch_done = fetch_acked && fetch_resp.complete;

    //////////////////////////////
    // State machine
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state             <= st_idle;
            pfb_rden          <= 1'b0;
            seq_rden          <= 1'b0;
            job_fetch_request <= 1'b0;
            fetch_acked       <= 1'b0;
            job_complete      <= 1'b0;
        end else begin
            // Read strobe is one cycle per word
            pfb_rden <= 1'b0;
            case (state)
                st_idle: begin
                    if (job_start) begin
                        state <= st_prime;
                    end
                end
                st_prime: begin
                    if (primed && !pfb_rden && pfb_count_d == pfb_count) begin
                        // Last read settled, hand over to the sequencer
                        state    <= st_active;
                        seq_rden <= 1'b1;
                    end else if (!primed && pfb_count == '0 && pfb_count_d == '0) begin
                        state <= st_wait_load;
                    end else if (!primed && !pfb_rden && pfb_count != '0) begin
                        // Every other cycle, so count and row are current
                        pfb_rden <= 1'b1;
                    end
                end
                st_wait_load: begin
                    if (fetch_done) begin
                        state             <= st_prime;
                        fetch_acked       <= 1'b0;
                        job_fetch_request <= 1'b0;
                    end else if (job_fetch_request && fetch_resp.ack) begin
                        job_fetch_request <= 1'b0;
                        fetch_acked       <= 1'b1;
                    end else if (!fetch_acked) begin
                        // Held until acked, one request per wait
                        job_fetch_request <= 1'b1;
                    end
                end
                st_active: begin
                    // Last output pixel of the map ends the job
                    if (next_row && out_map_end) begin
                        state        <= st_done;
                        seq_rden     <= 1'b0;
                        job_complete <= 1'b1;
                    end
                end
                st_done: begin
                    if (job_complete_ack) begin
                        state        <= st_idle;
                        job_complete <= 1'b0;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// File: design/quad_map_position.sv
module quad_map_position
    import quad_cfg_pkg::*;
    import quad_types_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     clear,
    input  logic     advance,
    input  job_cfg_t cfg,
    output map_pos_t pos,
    output logic     col_end,
    output logic     map_end
);

    // End flags come straight from the current position
    assign col_end = (pos.col == cfg.num_cols);
    assign map_end = col_end && (pos.row == cfg.num_rows);

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            pos <= '0;
        end else if (advance) begin
            if (col_end) begin
                // Wrap to the start of the next row
                pos.col <= '0;
                pos.row <= pos.row + 1'b1;
            end else begin
                pos.col <= pos.col + 1'b1;
            end
        end
    end

    // Row keeps counting past num_rows until the next clear
    // Only the flags matter to the FSM

endmodule

// File: design/quad_pfb_tracker.sv
module quad_pfb_tracker
    import quad_cfg_pkg::*;
    import quad_types_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetch_req,
    input  fetch_resp_t            fetch_resp,
    input  logic                   pfb_rden,
    output logic [PFB_COUNT_W-1:0] pfb_count,
    output logic [PFB_COUNT_W-1:0] pfb_count_d
);

    //////////////////////////////
    // Fetch tracking
    //////////////////////////////

    typedef enum logic {
        fetch_idle,
        fetch_requested
    } fetch_state_t;

    fetch_state_t fetch_state;
    logic         load;

    // Complete only counts once the request was acked
    assign load = (fetch_state == fetch_requested) && fetch_resp.complete;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_state <= fetch_idle;
        end else begin
            case (fetch_state)
                fetch_idle: begin
                    if (fetch_req && fetch_resp.ack) begin
                        fetch_state <= fetch_requested;
                    end
                end
                fetch_requested: begin
                    if (fetch_resp.complete) begin
                        fetch_state <= fetch_idle;
                    end
                end
                default: fetch_state <= fetch_idle;
            endcase
        end
    end

    //////////////////////////////
    // Word count
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pfb_count <= '0;
        end else if (load) begin
            pfb_count <= fetch_resp.full_count;
        end else if (pfb_rden) begin
            // One word leaves per read strobe
            pfb_count <= pfb_count - 1'b1;
        end
    end

    // Lagging copy lets the FSM see when the count has settled
    quad_delay_line #(
        .T     (logic [PFB_COUNT_W-1:0]),
        .DEPTH (1)
    ) count_delay (
        .clk  (clk),
        .rst  (rst),
        .din  (pfb_count),
        .dout (pfb_count_d)
    );

endmodule

// File: design/quad_seq_timing.sv
module quad_seq_timing
    import quad_cfg_pkg::*;
    import quad_types_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     seq_rden,
    input  logic     next_row,
    output seq_out_t seq_out
);

    logic                  seq_rden_d;
    logic                  cycle_inc;
    logic [CE_START_W-1:0] ce_start;
    logic [2:0]            cycle_counter;
    logic [1:0]            row_bin;

    //////////////////////////////
    // Read strobe delays
    //////////////////////////////

    // First stage lines up with the sequencer data
    quad_delay_line #(
        .T     (logic),
        .DEPTH (SEQ_RDEN_DELAY)
    ) rden_delay (
        .clk  (clk),
        .rst  (rst),
        .din  (seq_rden),
        .dout (seq_rden_d)
    );

    // Second stage paces the cycle counter
    quad_delay_line #(
        .T     (logic),
        .DEPTH (SEQ_RDEN_DELAY)
    ) inc_delay (
        .clk  (clk),
        .rst  (rst),
        .din  (seq_rden_d),
        .dout (cycle_inc)
    );

    //////////////////////////////
    // CE start chain and counters
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ce_start <= '0;
        end else begin
            // Each CE starts one cycle after its neighbour
            ce_start <= {ce_start[CE_START_W-2:0], seq_rden_d};
        end
    end

    always_ff @(posedge clk) begin
        if (rst || !cycle_inc) begin
            // Parked at zero between sequencing runs
            cycle_counter <= '0;
        end else if (cycle_counter == 3'(SEQ_CYCLES - 1)) begin
            cycle_counter <= '0;
        end else begin
            cycle_counter <= cycle_counter + 1'b1;
        end
    end

    // Binary row count, converted to Gray below
    always_ff @(posedge clk) begin
        if (rst) begin
            row_bin <= '0;
        end else if (next_row) begin
            row_bin <= row_bin + 1'b1;
        end
    end

    assign seq_out = '{
        ce_start:      ce_start,
        cycle_counter: cycle_counter,
        gray_code:     {row_bin[1], row_bin[1] ^ row_bin[0]}
    };

endmodule

// File: design/quad_types_pkg.sv
package quad_types_pkg;

    import quad_cfg_pkg::*;

    //////////////////////////////
    // Job and map
    //////////////////////////////

    // Highest row and column index of the padded input map
    typedef struct packed {
        logic [COORD_W-1:0] num_cols;
        logic [COORD_W-1:0] num_rows;
    } job_cfg_t;

    // Position inside the padded map
    typedef struct packed {
        logic [COORD_W-1:0] row;
        logic [COORD_W-1:0] col;
    } map_pos_t;

    //////////////////////////////
    // Environment replies
    //////////////////////////////

    // Fetch reply, complete carries the new PFB fill level
    typedef struct packed {
        logic                   ack;
        logic                   complete;
        logic [PFB_COUNT_W-1:0] full_count;
    } fetch_resp_t;

    // Sequencer side outputs toward the CEs
    typedef struct packed {
        logic [CE_START_W-1:0] ce_start;
        logic [2:0]            cycle_counter;
        logic [1:0]            gray_code;
    } seq_out_t;

    // Job phases, one-hot
    typedef enum logic [4:0] {
        st_idle      = 5'b00001,
        st_prime     = 5'b00010,
        st_wait_load = 5'b00100,
        st_active    = 5'b01000,
        st_done      = 5'b10000
    } job_state_t;

endpackage

// File: flist.f
design/quad_cfg_pkg.sv
design/quad_types_pkg.sv
design/quad_delay_line.sv
design/quad_map_position.sv
design/quad_pfb_tracker.sv
design/quad_seq_timing.sv
design/quad_job_fsm.sv
design/quad_bram_ctrl.sv
bench/quad_bram_ctrl_properties.sv
bench/quad_bram_ctrl_tb.sv
